/* nic_wrapper.f */
+incdir+.
host_bus_pkg.sv
nic_reg_pkg.sv
reset_sequencer.sv
host_target.sv
nic_regs.sv
nic_wrapper.sv
tb_nic_wrapper.sv

/* Makefile */
TOP = tb_nic_wrapper

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal -f nic_wrapper.f \
		--top-module $(TOP) -o V$(TOP)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

/* nic_trace.txt */
// op bar addr data cbe_n outcome rdata int_n
// op 1 write 2 read 3 phy (data bit 4 link, 1:0 speed) 4 busy high F end; outcome 1 term 2 abort
2 01 000000D0 00000000 0 1 00000000 1
1 01 000000D0 00000F0F 0 1 00000000 1
2 01 000000D0 00000000 0 1 00000F0F 1
1 01 000000D8 00000003 0 1 00000000 1
2 01 000000D8 00000000 0 1 00000F0C 1
1 01 000000D0 FFFFFFFF B 1 00000000 1
2 01 000000D0 00000000 0 1 00FF0F0C 1
1 01 000000D8 FFFFFFFF E 1 00000000 1
2 01 FEEC00D2 00000000 0 1 00FF0F00 1
3 00 00000000 00000002 0 0 00000000 1
2 01 00000008 00000000 0 1 00000080 1
1 01 00000008 FFFFFFFF 0 1 00000000 1
2 01 00000008 00000000 0 1 00000080 1
2 02 000000D0 00000000 0 2 00000000 1
1 80 00000000 12345678 0 2 00000000 1
2 01 00000100 00000000 0 2 00000000 1
1 01 00000010 DEADBEEF 0 2 00000000 1
2 01 00000000 00000000 0 1 00000000 1
1 01 000000D0 00000004 0 1 00000000 1
3 00 00000000 00000012 0 0 00000000 0
2 01 00000008 00000000 0 1 00000082 0
2 01 000000C0 00000000 0 1 00000004 1
2 01 000000C0 00000000 0 1 00000000 1
1 01 000000C8 00000004 0 1 00000000 0
1 01 000000C0 00000004 0 1 00000000 1
1 01 000000C8 00001000 0 1 00000000 1
1 01 000000C8 00000100 0 1 00000000 0
2 01 000000C0 00000000 0 1 00001100 1
1 01 000000D8 00000004 0 1 00000000 1
3 00 00000000 00000001 0 0 00000000 1
2 01 000000C0 00000000 0 1 00000004 1
2 01 00000008 00000000 0 1 00000040 1
1 01 00000000 000000A5 0 1 00000000 1
2 01 00000000 00000000 0 1 000000A5 1
1 01 000000C8 00000200 0 1 00000000 0
1 01 00000000 040000A5 0 1 00000000 0
4 00 00000000 00000000 0 0 00000000 0
2 01 000000D0 00000000 0 1 00000000 1
2 01 00000000 00000000 0 1 00000000 1
2 01 000000C0 00000000 0 1 00000000 1
2 01 00000008 00000000 0 1 00000040 1
F 00 00000000 00000000 0 0 00000000 0

/* tb_nic_wrapper.sv */
`timescale 1ns/100ps

module tb_nic_wrapper;

	localparam int MAX_LINES = 64;
	localparam int FIELDS = 8;
	localparam int BUSY_TIMEOUT = 64;
	localparam int DONE_TIMEOUT = 32;
	localparam int INT_TIMEOUT = 8;

	logic CLK;
	logic RST;
	logic host_addr_vld_i;
	host_bus_pkg::host_addr_t host_addr_i;
	host_bus_pkg::host_bar_t host_bar_hit_i;
	logic host_wrdn_i;
	host_bus_pkg::host_data_t host_wdata_i;
	host_bus_pkg::host_cbe_t host_cbe_i;
	host_bus_pkg::host_data_t host_rdata_o;
	logic host_term_o;
	logic host_abort_o;
	logic host_busy_o;
	logic phy_link_i;
	logic [1:0] phy_speed_i;
	logic int_n_o;

	logic [31:0] trace_mem [0:MAX_LINES*FIELDS-1];
	logic [15:0] lfsr_q;

	nic_wrapper nic_wrapper_i (
		.CLK(CLK),
		.RST(RST),
		.host_addr_vld_i(host_addr_vld_i),
		.host_addr_i(host_addr_i),
		.host_bar_hit_i(host_bar_hit_i),
		.host_wrdn_i(host_wrdn_i),
		.host_wdata_i(host_wdata_i),
		.host_cbe_i(host_cbe_i),
		.host_rdata_o(host_rdata_o),
		.host_term_o(host_term_o),
		.host_abort_o(host_abort_o),
		.host_busy_o(host_busy_o),
		.phy_link_i(phy_link_i),
		.phy_speed_i(phy_speed_i),
		.int_n_o(int_n_o)
	);

	initial begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK;
	end

	// Galois form of x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		logic [15:0] n;
		n = s >> 1;
		if (s[0])
			n = n ^ 16'hB400;
		return n;
	endfunction

	task automatic fail_and_stop();
		$display("SIMULATION FAILED");
		$fatal(1, "run stopped at the first failure");
	endtask

	task automatic check_data(input string name, input host_bus_pkg::host_data_t exp,
		input host_bus_pkg::host_data_t got);
		if (got !== exp) begin
			$display("error %s expected %h got %h", name, exp, got);
			fail_and_stop();
		end
	endtask

	// Outcome packed as {abort, term}
	task automatic check_outcome(input logic [1:0] exp, input logic term, input logic abort);
		if ({abort, term} !== exp) begin
			$display("error {host_abort_o,host_term_o} expected %h got %h", exp, {abort, term});
			fail_and_stop();
		end
	endtask

	task automatic check_int(input logic exp, input logic got);
		if (got !== exp) begin
			$display("error int_n_o expected %h got %h", exp, got);
			fail_and_stop();
		end
	endtask

	task automatic check_busy(input logic exp, input logic got);
		if (got !== exp) begin
			$display("error host_busy_o expected %h got %h", exp, got);
			fail_and_stop();
		end
	endtask

	task automatic idle_gap();
		logic [2:0] gap;
		gap = '0;
		for (int b = 0; b < 3; b++) begin
			gap = {gap[1:0], lfsr_q[0]};
			lfsr_q = lfsr_step(lfsr_q);
		end
		repeat (gap) @(posedge CLK);
	endtask

	task automatic wait_not_busy();
		int n;
		n = 0;
		@(negedge CLK);
		while (host_busy_o && n < BUSY_TIMEOUT) begin
			@(negedge CLK);
			n++;
		end
		if (host_busy_o) begin
			$display("timeout: host_busy_o stayed high");
			fail_and_stop();
		end
	endtask

	task automatic wait_done();
		int n;
		n = 0;
		@(negedge CLK);
		while (!host_term_o && !host_abort_o && n < DONE_TIMEOUT) begin
			@(negedge CLK);
			n++;
		end
		if (!host_term_o && !host_abort_o) begin
			$display("timeout: host cycle never completed");
			fail_and_stop();
		end
	endtask

	// Interrupt reacts to a PHY change a few clocks later and then holds
	task automatic wait_int(input logic exp);
		int n;
		n = 0;
		@(negedge CLK);
		while (int_n_o !== exp && n < INT_TIMEOUT) begin
			@(negedge CLK);
			n++;
		end
		check_int(exp, int_n_o);
		while (n < INT_TIMEOUT) begin
			@(negedge CLK);
			n++;
			check_int(exp, int_n_o);
		end
	endtask

	task automatic run_cycle(input logic wr, input host_bus_pkg::host_bar_t bar,
		input host_bus_pkg::host_addr_t addr, input host_bus_pkg::host_data_t data,
		input host_bus_pkg::host_cbe_t cbe);
		@(posedge CLK);
		host_addr_vld_i <= 1'b1;
		host_wrdn_i <= wr;
		host_bar_hit_i <= bar;
		host_addr_i <= addr;
		host_wdata_i <= data;
		host_cbe_i <= cbe;
		@(posedge CLK);
		host_addr_vld_i <= 1'b0;
		wait_done();
	endtask

	initial begin
		int base;
		int line_cnt;
		logic at_end;
		logic [3:0] op;
		logic [1:0] exp_out;

		RST = 1'b1;
		host_addr_vld_i = 1'b0;
		host_addr_i = '0;
		host_bar_hit_i = '0;
		host_wrdn_i = 1'b0;
		host_wdata_i = '0;
		host_cbe_i = '1;
		phy_link_i = 1'b0;
		phy_speed_i = 2'b00;
		lfsr_q = 16'd52633;
		line_cnt = 0;
		at_end = 1'b0;
		$readmemh("nic_trace.txt", trace_mem);

		repeat (10) @(posedge CLK);
		RST <= 1'b0;

		for (int ln = 0; ln < MAX_LINES && !at_end; ln++) begin
			base = ln * FIELDS;
			op = trace_mem[base][3:0];
			exp_out = trace_mem[base+5][1:0];
			case (op)
				4'h1, 4'h2: begin
					idle_gap();
					wait_not_busy();
					run_cycle(op == 4'h1, trace_mem[base+1][7:0], trace_mem[base+2],
						trace_mem[base+3], trace_mem[base+4][3:0]);
					check_outcome(exp_out, host_term_o, host_abort_o);
					if (op == 4'h2 && exp_out == 2'b01)
						check_data("host_rdata_o", trace_mem[base+6], host_rdata_o);
					check_int(trace_mem[base+7][0], int_n_o);
				end
				4'h3: begin
					idle_gap();
					@(posedge CLK);
					phy_link_i <= trace_mem[base+3][4];
					phy_speed_i <= trace_mem[base+3][1:0];
					wait_int(trace_mem[base+7][0]);
				end
				// Right after a software reset request
				4'h4: begin
					@(negedge CLK);
					check_busy(1'b1, host_busy_o);
				end
				4'hF: at_end = 1'b1;
				default: begin
					$display("unknown operation %h on trace line %0d", op, ln + 1);
					fail_and_stop();
				end
			endcase
			if (!at_end)
				line_cnt++;
		end

		if (!at_end || line_cnt == 0) begin
			$display("trace was empty or had no end marker");
			fail_and_stop();
		end else begin
			$display("SIMULATION PASSED");
			$finish;
		end
	end

endmodule

/* nic_wrapper.sv */
`timescale 1ns/100ps

module nic_wrapper (
	input  logic CLK,
	input  logic RST,

	input  logic host_addr_vld_i,
	input  host_bus_pkg::host_addr_t host_addr_i,
	input  host_bus_pkg::host_bar_t host_bar_hit_i,
	input  logic host_wrdn_i,
	input  host_bus_pkg::host_data_t host_wdata_i,
	input  host_bus_pkg::host_cbe_t host_cbe_i,
	output host_bus_pkg::host_data_t host_rdata_o,
	output logic host_term_o,
	output logic host_abort_o,
	output logic host_busy_o,

	input  logic phy_link_i,
	input  logic [1:0] phy_speed_i,
	output logic int_n_o
);

	logic nic_rst;
	logic rst_req;

	// Register link between target and register block
	logic awvalid;
	logic awready;
	nic_reg_pkg::reg_addr_t awaddr;
	logic wvalid;
	logic wready;
	host_bus_pkg::host_data_t wdata;
	logic [3:0] wstrb;
	logic bvalid;
	logic bready;
	nic_reg_pkg::axi_resp_t bresp;
	logic arvalid;
	logic arready;
	nic_reg_pkg::reg_addr_t araddr;
	logic rvalid;
	logic rready;
	host_bus_pkg::host_data_t rdata;
	nic_reg_pkg::axi_resp_t rresp;

	reset_sequencer reset_sequencer_i (
		.CLK(CLK),
		.RST(RST),
		.rst_req_i(rst_req),
		.nic_rst_o(nic_rst)
	);

	host_target host_target_i (
		.CLK(CLK),
		.RST(RST),
		.nic_rst_i(nic_rst),
		.host_addr_vld_i(host_addr_vld_i),
		.host_addr_i(host_addr_i),
		.host_bar_hit_i(host_bar_hit_i),
		.host_wrdn_i(host_wrdn_i),
		.host_wdata_i(host_wdata_i),
		.host_cbe_i(host_cbe_i),
		.host_rdata_o(host_rdata_o),
		.host_term_o(host_term_o),
		.host_abort_o(host_abort_o),
		.host_busy_o(host_busy_o),
		.awvalid_o(awvalid),
		.awaddr_o(awaddr),
		.wvalid_o(wvalid),
		.wdata_o(wdata),
		.wstrb_o(wstrb),
		.awready_i(awready),
		.wready_i(wready),
		.bvalid_i(bvalid),
		.bresp_i(bresp),
		.bready_o(bready),
		.arvalid_o(arvalid),
		.araddr_o(araddr),
		.arready_i(arready),
		.rvalid_i(rvalid),
		.rdata_i(rdata),
		.rresp_i(rresp),
		.rready_o(rready)
	);

	nic_regs nic_regs_i (
		.CLK(CLK),
		.RST(RST),
		.nic_rst_i(nic_rst),
		.awvalid_i(awvalid),
		.awaddr_i(awaddr),
		.awready_o(awready),
		.wvalid_i(wvalid),
		.wdata_i(wdata),
		.wstrb_i(wstrb),
		.wready_o(wready),
		.bvalid_o(bvalid),
		.bresp_o(bresp),
		.bready_i(bready),
		.arvalid_i(arvalid),
		.araddr_i(araddr),
		.arready_o(arready),
		.rvalid_o(rvalid),
		.rdata_o(rdata),
		.rresp_o(rresp),
		.rready_i(rready),
		.phy_link_i(phy_link_i),
		.phy_speed_i(phy_speed_i),
		.rst_req_o(rst_req),
		.int_n_o(int_n_o)
	);

endmodule

/* nic_regs.sv */
`timescale 1ns/100ps

module nic_regs (
	input  logic CLK,
	input  logic RST,
	input  logic nic_rst_i,

	input  logic awvalid_i,
	input  nic_reg_pkg::reg_addr_t awaddr_i,
	output logic awready_o,
	input  logic wvalid_i,
	input  host_bus_pkg::host_data_t wdata_i,
	input  logic [3:0] wstrb_i,
	output logic wready_o,
	output logic bvalid_o,
	output nic_reg_pkg::axi_resp_t bresp_o,
	input  logic bready_i,

	input  logic arvalid_i,
	input  nic_reg_pkg::reg_addr_t araddr_i,
	output logic arready_o,
	output logic rvalid_o,
	output host_bus_pkg::host_data_t rdata_o,
	output nic_reg_pkg::axi_resp_t rresp_o,
	input  logic rready_i,

	input  logic phy_link_i,
	input  logic [1:0] phy_speed_i,
	output logic rst_req_o,
	output logic int_n_o
);

	logic bvalid_q;
	logic rvalid_q;
	logic rst_req_q;
	logic int_n_q;
	logic link_q;
	logic pending;
	logic wr_accept;
	logic rd_accept;
	logic lsc;
	host_bus_pkg::host_data_t ctrl_q;
	host_bus_pkg::host_data_t icr_q;
	host_bus_pkg::host_data_t ims_q;
	host_bus_pkg::host_data_t status;
	host_bus_pkg::host_data_t bmask;
	host_bus_pkg::host_data_t wbits;
	host_bus_pkg::host_data_t ctrl_next;
	host_bus_pkg::host_data_t icr_set;
	host_bus_pkg::host_data_t icr_clr;
	host_bus_pkg::host_data_t rd_val;
	host_bus_pkg::host_data_t rdata_q;
	nic_reg_pkg::axi_resp_t bresp_q;
	nic_reg_pkg::axi_resp_t rresp_q;

	function automatic logic reg_mapped(input nic_reg_pkg::reg_addr_t a);
		case (a)
			nic_reg_pkg::REG_CTRL, nic_reg_pkg::REG_STATUS,
			nic_reg_pkg::REG_ICR, nic_reg_pkg::REG_ICS,
			nic_reg_pkg::REG_IMS, nic_reg_pkg::REG_IMC: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	assign pending = bvalid_q || rvalid_q;
	assign wr_accept = awvalid_i && wvalid_i && !pending && !nic_rst_i;
	assign awready_o = wr_accept;
	assign wready_o = wr_accept;
	// Writes win if both channels show up together
	assign arready_o = !pending && !nic_rst_i && !(awvalid_i && wvalid_i);
	assign rd_accept = arvalid_i && arready_o;
	assign lsc = (link_q != phy_link_i);

	always_comb begin
		for (int i = 0; i < 4; i++)
			bmask[8*i +: 8] = {8{wstrb_i[i]}};
	end
	assign wbits = wdata_i & bmask;

	always_comb begin
		status = '0;
		status[nic_reg_pkg::STATUS_LU] = phy_link_i;
		status[nic_reg_pkg::STATUS_SPEED +: 2] = phy_speed_i;
		ctrl_next = (ctrl_q & ~bmask) | wbits;
		ctrl_next[nic_reg_pkg::CTRL_RST] = 1'b0;
	end

	// New causes win over read to clear and write to clear
	always_comb begin
		icr_set = '0;
		icr_clr = '0;
		icr_set[nic_reg_pkg::ICR_LSC] = lsc;
		if (wr_accept && awaddr_i == nic_reg_pkg::REG_ICS)
			icr_set = icr_set | wbits;
		if (wr_accept && awaddr_i == nic_reg_pkg::REG_ICR)
			icr_clr = wbits;
		if (rd_accept && araddr_i == nic_reg_pkg::REG_ICR)
			icr_clr = '1;
	end

	always_comb begin
		case (araddr_i)
			nic_reg_pkg::REG_CTRL: rd_val = ctrl_q;
			nic_reg_pkg::REG_STATUS: rd_val = status;
			nic_reg_pkg::REG_ICR: rd_val = icr_q;
			nic_reg_pkg::REG_IMS, nic_reg_pkg::REG_IMC: rd_val = ims_q;
			// ICS is write only
			default: rd_val = '0;
		endcase
	end

	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			bvalid_q <= 1'b0;
			rvalid_q <= 1'b0;
			rst_req_q <= 1'b0;
			int_n_q <= 1'b1;
			ctrl_q <= '0;
			icr_q <= '0;
			ims_q <= '0;
		end else if (nic_rst_i) begin
			bvalid_q <= 1'b0;
			rvalid_q <= 1'b0;
			rst_req_q <= 1'b0;
			int_n_q <= 1'b1;
			ctrl_q <= '0;
			icr_q <= '0;
			ims_q <= '0;
		end else begin
			if (wr_accept)
				bvalid_q <= 1'b1;
			else if (bready_i)
				bvalid_q <= 1'b0;
			if (rd_accept)
				rvalid_q <= 1'b1;
			else if (rready_i)
				rvalid_q <= 1'b0;
			rst_req_q <= wr_accept && awaddr_i == nic_reg_pkg::REG_CTRL &&
				wbits[nic_reg_pkg::CTRL_RST];
			if (wr_accept && awaddr_i == nic_reg_pkg::REG_CTRL)
				ctrl_q <= ctrl_next;
			if (wr_accept && awaddr_i == nic_reg_pkg::REG_IMS)
				ims_q <= ims_q | wbits;
			if (wr_accept && awaddr_i == nic_reg_pkg::REG_IMC)
				ims_q <= ims_q & ~wbits;
			icr_q <= (icr_q & ~icr_clr) | icr_set;
			int_n_q <= !(|(icr_q & ims_q));
		end
	end

	// Link level follows the PHY also while the NIC is held in reset
	always_ff @(posedge CLK or posedge RST) begin
		if (RST)
			link_q <= 1'b0;
		else
			link_q <= phy_link_i;
	end

	always_ff @(posedge CLK) begin
		if (wr_accept)
			bresp_q <= reg_mapped(awaddr_i) ? nic_reg_pkg::RESP_OKAY : nic_reg_pkg::RESP_SLVERR;
		if (rd_accept) begin
			rdata_q <= rd_val;
			rresp_q <= reg_mapped(araddr_i) ? nic_reg_pkg::RESP_OKAY : nic_reg_pkg::RESP_SLVERR;
		end
	end

	assign bvalid_o = bvalid_q;
	assign bresp_o = bresp_q;
	assign rvalid_o = rvalid_q;
	assign rdata_o = rdata_q;
	assign rresp_o = rresp_q;
	assign rst_req_o = rst_req_q;
	assign int_n_o = int_n_q;

	// Master keeps the request stable until it is taken
	a_aw_stable: assert property (
		@(posedge CLK) disable iff (RST)
		awvalid_i && !awready_o |=> awvalid_i && wvalid_i && $stable(awaddr_i)
	) else $error("write request dropped or changed before ready");

	a_ar_stable: assert property (
		@(posedge CLK) disable iff (RST)
		arvalid_i && !arready_o |=> arvalid_i && $stable(araddr_i)
	) else $error("read request dropped or changed before ready");

endmodule

/* host_target.sv */
`timescale 1ns/100ps
`include "nic_bridge_cfg.svh"

module host_target (
	input  logic CLK,
	input  logic RST,
	input  logic nic_rst_i,

	input  logic host_addr_vld_i,
	input  host_bus_pkg::host_addr_t host_addr_i,
	input  host_bus_pkg::host_bar_t host_bar_hit_i,
	input  logic host_wrdn_i,
	input  host_bus_pkg::host_data_t host_wdata_i,
	input  host_bus_pkg::host_cbe_t host_cbe_i,
	output host_bus_pkg::host_data_t host_rdata_o,
	output logic host_term_o,
	output logic host_abort_o,
	output logic host_busy_o,

	output logic awvalid_o,
	output nic_reg_pkg::reg_addr_t awaddr_o,
	output logic wvalid_o,
	output host_bus_pkg::host_data_t wdata_o,
	output logic [3:0] wstrb_o,
	input  logic awready_i,
	input  logic wready_i,
	input  logic bvalid_i,
	input  nic_reg_pkg::axi_resp_t bresp_i,
	output logic bready_o,

	output logic arvalid_o,
	output nic_reg_pkg::reg_addr_t araddr_o,
	input  logic arready_i,
	input  logic rvalid_i,
	input  host_bus_pkg::host_data_t rdata_i,
	input  nic_reg_pkg::axi_resp_t rresp_i,
	output logic rready_o
);

	typedef enum logic [2:0] {
		IDLE,
		WR_ADDR,
		WR_RESP,
		RD_ADDR,
		RD_RESP,
		DONE
	} state_t;

	state_t state_q;
	logic term_q;
	logic abort_q;
	logic awvalid_q;
	logic wvalid_q;
	logic arvalid_q;
	nic_reg_pkg::reg_addr_t addr_q;
	host_bus_pkg::host_data_t wdata_q;
	logic [3:0] wstrb_q;
	host_bus_pkg::host_data_t rdata_q;
	logic reg_hit;
	logic aw_done;
	logic w_done;

	assign reg_hit = host_bar_hit_i[`NIC_REG_BAR];
	assign aw_done = awready_i || !awvalid_q;
	assign w_done = wready_i || !wvalid_q;

	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			state_q <= IDLE;
			term_q <= 1'b0;
			abort_q <= 1'b0;
			awvalid_q <= 1'b0;
			wvalid_q <= 1'b0;
			arvalid_q <= 1'b0;
		end else begin
			term_q <= 1'b0;
			abort_q <= 1'b0;
			case (state_q)
				IDLE: begin
					if (host_addr_vld_i && !reg_hit) begin
						abort_q <= 1'b1;
						state_q <= DONE;
					end else if (host_addr_vld_i && host_wrdn_i) begin
						awvalid_q <= 1'b1;
						wvalid_q <= 1'b1;
						state_q <= WR_ADDR;
					end else if (host_addr_vld_i) begin
						arvalid_q <= 1'b1;
						state_q <= RD_ADDR;
					end
				end
				// Address and data channels may be taken in different clocks
				WR_ADDR: begin
					if (awready_i)
						awvalid_q <= 1'b0;
					if (wready_i)
						wvalid_q <= 1'b0;
					if (aw_done && w_done)
						state_q <= WR_RESP;
				end
				WR_RESP: begin
					if (bvalid_i) begin
						term_q <= (bresp_i != nic_reg_pkg::RESP_SLVERR);
						abort_q <= (bresp_i == nic_reg_pkg::RESP_SLVERR);
						state_q <= DONE;
					end
				end
				RD_ADDR: begin
					if (arready_i) begin
						arvalid_q <= 1'b0;
						state_q <= RD_RESP;
					end
				end
				RD_RESP: begin
					if (rvalid_i) begin
						term_q <= (rresp_i != nic_reg_pkg::RESP_SLVERR);
						abort_q <= (rresp_i == nic_reg_pkg::RESP_SLVERR);
						state_q <= DONE;
					end
				end
				DONE: state_q <= IDLE;
				default: state_q <= IDLE;
			endcase
		end
	end

	// Word aligned offset inside the BAR window
	always_ff @(posedge CLK) begin
		if (state_q == IDLE && host_addr_vld_i) begin
			addr_q <= {host_addr_i[`NIC_ADDR_BITS-1:2], 2'b00};
			wdata_q <= host_wdata_i;
			wstrb_q <= ~host_cbe_i;
		end
		if (state_q == RD_RESP && rvalid_i)
			rdata_q <= rdata_i;
	end

	assign awvalid_o = awvalid_q;
	assign awaddr_o = addr_q;
	assign wvalid_o = wvalid_q;
	assign wdata_o = wdata_q;
	assign wstrb_o = wstrb_q;
	assign bready_o = 1'b1;
	assign arvalid_o = arvalid_q;
	assign araddr_o = addr_q;
	assign rready_o = 1'b1;

	assign host_rdata_o = rdata_q;
	assign host_term_o = term_q;
	assign host_abort_o = abort_q;
	assign host_busy_o = (state_q != IDLE) || nic_rst_i;

	a_no_start_busy: assert property (
		@(posedge CLK) disable iff (RST)
		host_addr_vld_i |-> !host_busy_o
	) else $error("host cycle started while target busy");

	a_term_abort: assert property (
		@(posedge CLK) disable iff (RST)
		!(host_term_o && host_abort_o)
	) else $error("term and abort in the same clock");

endmodule

/* reset_sequencer.sv */
`timescale 1ns/100ps
`include "nic_bridge_cfg.svh"

module reset_sequencer (
	input  logic CLK,
	input  logic RST,
	input  logic rst_req_i,
	output logic nic_rst_o
);

	localparam int CNT_BITS = $clog2(`NIC_RST_CYCLES + 1);
	localparam logic [CNT_BITS-1:0] CNT_DONE = CNT_BITS'(`NIC_RST_CYCLES);

	logic [CNT_BITS-1:0] cnt_q;
	logic done;

	assign done = (cnt_q == CNT_DONE);

	// Saturates at CNT_DONE and restarts on a software request
	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			cnt_q <= '0;
		end else if (rst_req_i) begin
			cnt_q <= '0;
		end else if (!done) begin
			cnt_q <= cnt_q + 1'b1;
		end
	end

	assign nic_rst_o = !done;

	// Request from the register block is a single clock pulse
	a_req_pulse: assert property (
		@(posedge CLK) disable iff (RST)
		rst_req_i |=> !rst_req_i
	) else $error("reset request held for more than one clock");

endmodule

/* nic_reg_pkg.sv */
`include "nic_bridge_cfg.svh"

package nic_reg_pkg;

	typedef logic [`NIC_ADDR_BITS-1:0] reg_addr_t;
	typedef logic [1:0] axi_resp_t;

	localparam axi_resp_t RESP_OKAY = 2'b00;
	localparam axi_resp_t RESP_SLVERR = 2'b10;

	// Register offsets in the BAR window
	localparam reg_addr_t REG_CTRL = reg_addr_t'(32'h0000);
	localparam reg_addr_t REG_STATUS = reg_addr_t'(32'h0008);
	localparam reg_addr_t REG_ICR = reg_addr_t'(32'h00C0);
	localparam reg_addr_t REG_ICS = reg_addr_t'(32'h00C8);
	localparam reg_addr_t REG_IMS = reg_addr_t'(32'h00D0);
	localparam reg_addr_t REG_IMC = reg_addr_t'(32'h00D8);

	// Bit positions
	localparam int CTRL_RST = 26;
	localparam int STATUS_LU = 1;
	// Low bit of the two bit speed field
	localparam int STATUS_SPEED = 6;
	localparam int ICR_LSC = 2;

endpackage

/* host_bus_pkg.sv */
package host_bus_pkg;

	// Host cycle address
	typedef logic [31:0] host_addr_t;

	// Single beat data word for both directions
	typedef logic [31:0] host_data_t;

	// Active low byte enables as on the host bus
	typedef logic [3:0] host_cbe_t;

	// One bit per base address register
	typedef logic [7:0] host_bar_t;

endpackage

/* nic_bridge_cfg.svh */
`ifndef NIC_BRIDGE_CFG_SVH
`define NIC_BRIDGE_CFG_SVH

// 128 KB register window seen through the BAR
`define NIC_ADDR_BITS 17

// Base address hit bit that maps the register block
`define NIC_REG_BAR 0

// Clocks the NIC side stays in reset
`define NIC_RST_CYCLES 16

`endif
